//--- src.f
hdl/sine_fixed_pkg.sv
hdl/sine_stream_pkg.sv
hdl/phase_accum.sv
hdl/sample_fifo.sv
hdl/round_mult.sv
hdl/sine_pipe.sv
hdl/sine_gen_top.sv
verification/sine_gen_checker.sv
verification/sine_gen_asserts.sv
verification/sine_gen_tb.sv

//--- Makefile
# Verilator lint and simulation of the sine tone generator

TOP := sine_gen_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f src.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f src.f -Mdir obj_dir -o sim_bin
	./obj_dir/sim_bin > sim.log 2>&1 || true
	cat sim.log
	grep -q "^=== PASS ===$$" sim.log

clean:
	rm -rf obj_dir sim.log

//--- verification/sine_gen_tb.sv
// Testbench top for the sine tone generator that runs the stimulus sequences and prints the verdict
`timescale 1ns/1ps
`default_nettype none

module sine_gen_tb;

	import sine_fixed_pkg::*;
	import sine_stream_pkg::*;

	localparam int WAIT_LIMIT = 5000;

	logic      clk;
	logic      rst_n;
	logic      step_load;
	fixed_t    step;
	logic      run;
	logic      hold;
	sine_out_t out;
	logic      out_valid;

	int seed;
	int tb_errors = 0;
	int push_count = 0;
	int sample_count;
	int error_count;
	int neg_count;

	sine_gen_top u_sine_gen_top (
		.clk      (clk),
		.rst_n    (rst_n),
		.step_load(step_load),
		.step     (step),
		.run      (run),
		.hold     (hold),
		.out      (out),
		.out_valid(out_valid)
	);

	sine_gen_checker u_checker (
		.clk         (clk),
		.rst_n       (rst_n),
		.step_load   (step_load),
		.step        (step),
		.out         (out),
		.out_valid   (out_valid),
		.sample_count(sample_count),
		.error_count (error_count),
		.neg_count   (neg_count)
	);

	always #50 clk = ~clk;

	// count angles handed to the buffer
	always @(posedge clk) begin
		if (rst_n && u_sine_gen_top.push) begin
			push_count++;
		end
	end

	task automatic load_step(input fixed_t value);
		@(negedge clk);
		step_load = 1'b1;
		step = value;
		@(negedge clk);
		step_load = 1'b0;
	endtask

	// keep running until the checker has seen enough samples
	task automatic await_samples(input int target, input bit random_hold);
		int cycles;
		cycles = 0;
		while (sample_count < target && cycles < WAIT_LIMIT) begin
			@(negedge clk);
			if (random_hold) begin
				hold = 1'($random(seed));
			end else begin
				hold = 1'b0;
			end
			cycles++;
		end
		if (sample_count < target) begin
			$display("timeout while waiting for samples, got %0d of %0d", sample_count, target);
			tb_errors++;
		end
	endtask

	// stop the producer and let every buffered angle come out
	task automatic drain();
		int cycles;
		@(negedge clk);
		run = 1'b0;
		hold = 1'b0;
		cycles = 0;
		while (sample_count < push_count && cycles < WAIT_LIMIT) begin
			@(negedge clk);
			cycles++;
		end
		if (sample_count < push_count) begin
			$display("timeout while draining, %0d of %0d angles came out", sample_count, push_count);
			tb_errors++;
		end
		repeat (2 * SINE_LATENCY) @(negedge clk);
		if (sample_count != push_count) begin
			$display("%0d samples came out for %0d pushed angles", sample_count, push_count);
			tb_errors++;
		end
	endtask

	task automatic run_tone(input fixed_t value, input int count, input bit random_hold);
		int target;
		load_step(value);
		target = sample_count + count;
		run = 1'b1;
		await_samples(target, random_hold);
		drain();
	endtask

	initial begin
		int neg_before;
		int assert_errors;
		fixed_t rand_step;
		seed = 68514;
		clk = 1'b0;
		rst_n = 1'b0;
		step_load = 1'b0;
		step = '0;
		run = 1'b0;
		hold = 1'b0;
		repeat (16) @(negedge clk);
		rst_n = 1'b1;

		// idle with run low
		for (int i = 0; i < 50; i++) begin
			@(negedge clk);
			if (out_valid !== 1'b0) begin
				$display("error at %0t: out_valid expected 0 got %b", $time, out_valid);
				tb_errors++;
			end
		end

		run_tone(fixed_t'(10), 40, 1'b0);

		// big step wraps past pi into negative angles
		neg_before = neg_count;
		run_tone(fixed_t'(700), 40, 1'b0);
		if (neg_count == neg_before) begin
			$display("no negative angle appeared although the step crosses pi");
			tb_errors++;
		end

		rand_step = fixed_t'(1 + ($unsigned($random(seed)) % (PI_Q - 1)));
		run_tone(rand_step, 80, 1'b1);

		// reload after drain so the phase starts over at zero
		run_tone(fixed_t'(333), 30, 1'b0);

		assert_errors = u_sine_gen_top.u_asserts.fail_count;
		$display("errors: checker %0d, assertions %0d, testbench %0d; samples checked %0d",
			error_count, assert_errors, tb_errors, sample_count);
		if (error_count == 0 && assert_errors == 0 && tb_errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- verification/sine_gen_asserts.sv
// Concurrent assertions on buffer flow and the output strobe that bind into the generator top level
`timescale 1ns/1ps
`default_nettype none

module sine_gen_asserts (
	input logic clk,
	input logic rst_n,
	input logic push,
	input logic full,
	input logic take,
	input logic empty,
	input logic hold,
	input logic out_valid
);

	int fail_count = 0;

	// producer respects the full level
	a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n) !(push && full))
		else begin
			$error("push while the buffer is full");
			fail_count++;
		end

	a_no_take_empty: assert property (@(posedge clk) disable iff (!rst_n) !(take && empty))
		else begin
			$error("take while the buffer is empty");
			fail_count++;
		end

	// frozen pipeline emits nothing
	a_quiet_on_hold: assert property (@(posedge clk) disable iff (!rst_n) !(hold && out_valid))
		else begin
			$error("out_valid high while hold is high");
			fail_count++;
		end

	a_valid_known: assert property (@(posedge clk) disable iff (!rst_n) !$isunknown(out_valid))
		else begin
			$error("out_valid is unknown after reset");
			fail_count++;
		end

endmodule

bind sine_gen_top sine_gen_asserts u_asserts (
	.clk      (clk),
	.rst_n    (rst_n),
	.push     (push),
	.full     (full),
	.take     (take),
	.empty    (empty),
	.hold     (hold),
	.out_valid(out_valid)
);

`default_nettype wire

//--- verification/sine_gen_checker.sv
// Reference model and scoreboard that checks every output sample of the sine generator
`timescale 1ns/1ps
`default_nettype none

module sine_gen_checker (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       step_load,
	input  sine_fixed_pkg::fixed_t     step,
	input  sine_stream_pkg::sine_out_t out,
	input  logic                       out_valid,
	output int                         sample_count,
	output int                         error_count,
	output int                         neg_count
);

	import sine_fixed_pkg::*;

	fixed_t exp_step;
	fixed_t exp_phase;
	fixed_t want_sin;

	// word product, half-up at bit 7, result word taken from bits 34..8
	function automatic fixed_t mul_round(input longint a, input longint b);
		longint p;
		p = (a * b + 128) >>> FRAC_W;
		return fixed_t'(p);
	endfunction

	// rough parabola first, then the refinement step
	function automatic fixed_t ref_sine(input fixed_t x);
		fixed_t x2;
		fixed_t k1x;
		fixed_t k2x2;
		fixed_t est;
		fixed_t est2;
		fixed_t est_abs_sq;
		fixed_t diff;
		x2 = mul_round(x, x);
		k1x = mul_round(x, COEF_K1);
		k2x2 = mul_round(x2, COEF_K2);
		// second term takes the sign of x
		est = (x < 0) ? k1x + k2x2 : k1x - k2x2;
		est2 = mul_round(est, est);
		est_abs_sq = (est < 0) ? -est2 : est2;
		diff = est_abs_sq - est;
		return mul_round(diff, COEF_K3) + est;
	endfunction

	// next angle, wrapped back into [-pi, pi)
	function automatic fixed_t advance(input fixed_t ph, input fixed_t st);
		int sum;
		sum = ph + st;
		if (sum >= PI_Q) begin
			sum = sum - TWO_PI_Q;
		end
		return fixed_t'(sum);
	endfunction

	always @(posedge clk) begin
		if (!rst_n) begin
			exp_step = '0;
			exp_phase = '0;
			sample_count = 0;
			error_count = 0;
			neg_count = 0;
		end else begin
			if (out_valid) begin
				sample_count = sample_count + 1;
				if (out.angle < 0) begin
					neg_count = neg_count + 1;
				end
				want_sin = ref_sine(exp_phase);
				if (out.angle !== exp_phase) begin
					$display("error at %0t: out.angle expected %0d got %0d",
						$time, exp_phase, out.angle);
					error_count = error_count + 1;
				end
				if (out.sin !== want_sin) begin
					$display("error at %0t: out.sin expected %0d got %0d",
						$time, want_sin, out.sin);
					error_count = error_count + 1;
				end
				exp_phase = advance(exp_phase, exp_step);
			end
			// a load restarts the angle sequence from zero
			if (step_load) begin
				exp_step = step;
				exp_phase = '0;
			end
		end
	end

endmodule

`default_nettype wire

//--- hdl/sine_gen_top.sv
// Sine tone generator top level joining phase accumulator, sample buffer and sine pipeline
`timescale 1ns/1ps
`default_nettype none

module sine_gen_top (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       step_load,
	input  sine_fixed_pkg::fixed_t     step,
	input  logic                       run,
	input  logic                       hold,
	output sine_stream_pkg::sine_out_t out,
	output logic                       out_valid
);

	import sine_stream_pkg::*;

	logic          push;
	logic          full;
	logic          take;
	logic          empty;
	phase_sample_t sample;
	phase_sample_t head;

	// producer
	phase_accum u_phase_accum (
		.clk      (clk),
		.rst_n    (rst_n),
		.step_load(step_load),
		.step     (step),
		.run      (run),
		.full     (full),
		.push     (push),
		.sample   (sample)
	);

	sample_fifo u_sample_fifo (
		.clk      (clk),
		.rst_n    (rst_n),
		.push     (push),
		.push_data(sample),
		.full     (full),
		.take     (take),
		.head     (head),
		.empty    (empty)
	);

	// consumer
	sine_pipe u_sine_pipe (
		.clk      (clk),
		.rst_n    (rst_n),
		.hold     (hold),
		.head     (head),
		.empty    (empty),
		.take     (take),
		.out      (out),
		.out_valid(out_valid)
	);

endmodule

`default_nettype wire

//--- hdl/sine_pipe.sv
// Stallable pipeline computing the two-step parabolic sine approximation of buffered angles
`timescale 1ns/1ps
`default_nettype none

module sine_pipe (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic                           hold,
	input  sine_stream_pkg::phase_sample_t head,
	input  logic                           empty,
	output logic                           take,
	output sine_stream_pkg::sine_out_t     out,
	output logic                           out_valid
);

	import sine_fixed_pkg::*;
	import sine_stream_pkg::*;

	logic en;

	// angle delay line, index k holds the angle k edges after capture
	fixed_t ang_d [SINE_LATENCY];
	logic [SINE_LATENCY:0] vld;

	fixed_t x_sq;
	fixed_t k1x;
	fixed_t k1x_d [MULT_LATENCY];
	fixed_t k2x2;
	fixed_t est;
	fixed_t est_d [2*MULT_LATENCY+2];
	fixed_t est_sq;
	fixed_t est_norm;
	fixed_t diff;
	fixed_t k3p;
	sine_out_t out_q;

	// one enable freezes every stage
	assign en   = ~hold;
	assign take = ~hold & ~empty;

	// edges 1-2
	round_mult sq_x (
		.clk(clk), .rst_n(rst_n), .en(en),
		.a(ang_d[0]), .b(ang_d[0]), .product(x_sq)
	);

	round_mult k1_x (
		.clk(clk), .rst_n(rst_n), .en(en),
		.a(ang_d[0]), .b(fixed_t'(COEF_K1)), .product(k1x)
	);

	// edges 3-4
	round_mult k2_x2 (
		.clk(clk), .rst_n(rst_n), .en(en),
		.a(x_sq), .b(fixed_t'(COEF_K2)), .product(k2x2)
	);

	// edges 6-7
	round_mult sq_est (
		.clk(clk), .rst_n(rst_n), .en(en),
		.a(est), .b(est), .product(est_sq)
	);

	// edges 10-11
	round_mult k3_diff (
		.clk(clk), .rst_n(rst_n), .en(en),
		.a(diff), .b(fixed_t'(COEF_K3)), .product(k3p)
	);

	// valid bits are the only control state here
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			vld <= '0;
		end else if (en) begin
			vld <= {vld[SINE_LATENCY-1:0], ~empty};
		end
	end

	always_ff @(posedge clk) begin
		if (en) begin
			// capture the buffer head on the take edge
			ang_d[0] <= head.angle;
			for (int k = 1; k < SINE_LATENCY; k++) begin
				ang_d[k] <= ang_d[k-1];
			end

			// k1*x waits for k2*x^2
			k1x_d[0] <= k1x;
			for (int k = 1; k < MULT_LATENCY; k++) begin
				k1x_d[k] <= k1x_d[k-1];
			end

			// edge 5, x*|x| folded into the add/subtract choice
			if (ang_d[4][WORD_W-1]) begin
				est <= k1x_d[MULT_LATENCY-1] + k2x2;
			end else begin
				est <= k1x_d[MULT_LATENCY-1] - k2x2;
			end

			// est kept for the sign, the difference and the final sum
			est_d[0] <= est;
			for (int k = 1; k < 2*MULT_LATENCY+2; k++) begin
				est_d[k] <= est_d[k-1];
			end

			// edge 8, est*|est|
			est_norm <= est_d[1][WORD_W-1] ? -est_sq : est_sq;

			// edge 9
			diff <= est_norm - est_d[2];

			// edge 12, refined sine next to its angle
			out_q.angle <= ang_d[SINE_LATENCY-1];
			out_q.sin   <= k3p + est_d[2*MULT_LATENCY+1];
		end
	end

	assign out = out_q;

	// a held result shows again once hold drops and is consumed on that enabled edge
	assign out_valid = vld[SINE_LATENCY] & ~hold;

endmodule

`default_nettype wire

//--- hdl/round_mult.sv
// Two-stage signed fixed-point multiplier with half-up rounding, stalled by its enable
`timescale 1ns/1ps
`default_nettype none

module round_mult (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   en,
	input  sine_fixed_pkg::fixed_t a,
	input  sine_fixed_pkg::fixed_t b,
	output sine_fixed_pkg::fixed_t product
);

	import sine_fixed_pkg::*;

	prod_t full_q;

	// first stage keeps the whole signed product
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			full_q <= '0;
		end else if (en) begin
			full_q <= a * b;
		end
	end

	// second stage rounds back to the word format
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			product <= '0;
		end else if (en) begin
			product <= round_product(full_q);
		end
	end

endmodule

`default_nettype wire

//--- hdl/sample_fifo.sv
// Show-ahead circular buffer that carries angle samples from the accumulator to the sine pipeline
`timescale 1ns/1ps
`default_nettype none

module sample_fifo (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic                           push,
	input  sine_stream_pkg::phase_sample_t push_data,
	output logic                           full,
	input  logic                           take,
	output sine_stream_pkg::phase_sample_t head,
	output logic                           empty
);

	import sine_stream_pkg::*;

	phase_sample_t         mem [FIFO_DEPTH];
	logic [FIFO_PTR_W-1:0] wr_ptr;
	logic [FIFO_PTR_W-1:0] rd_ptr;
	logic [FIFO_PTR_W:0]   count;
	logic                  do_write;
	logic                  do_read;

	assign full  = (count == (FIFO_PTR_W + 1)'(FIFO_DEPTH));
	assign empty = (count == '0);

	// oldest entry always on the output
	assign head = mem[rd_ptr];

	assign do_write = push & ~full;
	assign do_read  = take & ~empty;

	// storage only, no reset
	always_ff @(posedge clk) begin
		if (do_write) begin
			mem[wr_ptr] <= push_data;
		end
	end

	// depth is a power of two, pointers wrap on their own
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_write) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_read) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			// simultaneous push and pop leaves the count alone
			if (do_write && !do_read) begin
				count <= count + 1'b1;
			end else if (do_read && !do_write) begin
				count <= count - 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- hdl/phase_accum.sv
// Phase accumulator that emits one wrapped angle per cycle into the sample buffer while run allows
`timescale 1ns/1ps
`default_nettype none

module phase_accum (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic                           step_load,
	input  sine_fixed_pkg::fixed_t         step,
	input  logic                           run,
	input  logic                           full,
	output logic                           push,
	output sine_stream_pkg::phase_sample_t sample
);

	import sine_fixed_pkg::*;

	fixed_t step_q;
	fixed_t phase;
	fixed_t phase_sum;
	fixed_t phase_next;

	// produce whenever running and the buffer has room
	assign push = run & ~full;

	// current phase goes out, the update lands on the same edge
	assign sample.angle = phase;

	// step stays below pi so one subtraction is enough to wrap
	always_comb begin
		phase_sum = phase + step_q;
		if (phase_sum >= fixed_t'(PI_Q)) begin
			phase_next = phase_sum - fixed_t'(TWO_PI_Q);
		end else begin
			phase_next = phase_sum;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			step_q <= '0;
			phase  <= '0;
		end else if (step_load) begin
			// new increment, restart from zero
			step_q <= step;
			phase  <= '0;
		end else if (push) begin
			phase <= phase_next;
		end
	end

endmodule

`default_nettype wire

//--- hdl/sine_stream_pkg.sv
// Sample and output record types plus buffer sizing; import where samples move between blocks
`default_nettype none

package sine_stream_pkg;

	// buffer between accumulator and sine pipeline
	localparam int FIFO_DEPTH = 8;
	localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);

	// one angle headed for the sine pipeline
	typedef struct packed {
		sine_fixed_pkg::fixed_t angle;
	} phase_sample_t;

	// result record, angle kept alongside its sine
	typedef struct packed {
		sine_fixed_pkg::fixed_t angle;
		sine_fixed_pkg::fixed_t sin;
	} sine_out_t;

endpackage

`default_nettype wire

//--- hdl/sine_fixed_pkg.sv
// Fixed-point number format, sine coefficients and phase constants; import wherever angles are handled
`default_nettype none

package sine_fixed_pkg;

	// 27-bit two's complement words with 8 fraction bits
	localparam int WORD_W = 27;
	localparam int FRAC_W = 8;
	localparam int PROD_W = 2 * WORD_W;

	// parabolic approximation coefficients, scaled by 2**FRAC_W
	localparam int COEF_K1 = 326;
	localparam int COEF_K2 = 104;
	localparam int COEF_K3 = 58;

	// pi and 2*pi in the same scale
	localparam int PI_Q = 804;
	localparam int TWO_PI_Q = 1608;

	// enabled cycles through one rounded multiply and through the sine pipeline
	localparam int MULT_LATENCY = 2;
	localparam int SINE_LATENCY = 12;

	typedef logic signed [WORD_W-1:0] fixed_t;
	typedef logic signed [PROD_W-1:0] prod_t;

	// half-up on the first dropped bit, then keep the word above the fraction
	function automatic fixed_t round_product(input prod_t p);
		fixed_t r;
		r = fixed_t'(p[WORD_W+FRAC_W-1:FRAC_W] + p[FRAC_W-1]);
		return r;
	endfunction

endpackage

`default_nettype wire
